// File: src.f
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_exec.sv
hw/rv_lsu.sv
hw/rv_bus_arb.sv
hw/rv_core.sv
+incdir+tb
tb/tb_core.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_core -f src.f -o sim_tb_core
./obj_dir/sim_tb_core 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log; then
	exit 1
fi
exit 0

// File: tb/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam logic [31:0] STOP_ADDR = RESET_PC + 32'h3fc;

logic [31:0] lfsr_state = 32'd29;
logic [31:0] exp_addr [$]; // expected stores in order
logic [31:0] exp_data [$];

function automatic logic lfsr_bit();
	logic lsb;
	lsb = lfsr_state[0];
	lfsr_state = lfsr_state >> 1;
	if (lsb)
		lfsr_state = lfsr_state ^ 32'ha300_0000;
	return lsb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = 32'h0;
	for (int i = 0; i < n; i++)
		r = {r[30:0], lfsr_bit()};
	return r;
endfunction

// runs the image on an ISA model up to the stop store and returns the instruction count
function automatic int ref_run();
	logic [31:0] r [16];
	logic [31:0] m [256];
	logic [31:0] pc, npc, ins, a, b, op_b, v, ea, iimm, simm, bimm, jimm;
	logic        wr, taken;
	int          n;
	for (int i = 0; i < 16; i++)
		r[i] = 32'h0;
	for (int i = 0; i < 256; i++)
		m[i] = img[i];
	exp_addr.delete();
	exp_data.delete();
	pc = RESET_PC;
	n = 0;
	while (n < 5000) begin
		n++;
		ins = m[pc[9:2]];
		a = r[ins[18:15]];
		b = r[ins[23:20]];
		iimm = {{20{ins[31]}}, ins[31:20]};
		simm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		bimm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		jimm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		npc = pc + 32'd4;
		wr = 1'b0;
		v = 32'h0;
		case (ins[6:0])
			OP_LUI: begin
				v = {ins[31:12], 12'h0};
				wr = 1'b1;
			end
			OP_AUIPC: begin
				v = pc + {ins[31:12], 12'h0};
				wr = 1'b1;
			end
			OP_JAL: begin
				v = pc + 32'd4;
				wr = 1'b1;
				npc = pc + jimm;
			end
			OP_JALR: begin
				v = pc + 32'd4;
				wr = 1'b1;
				npc = (a + iimm) & ~32'h1;
			end
			OP_BRANCH: begin
				case (ins[14:12])
					3'b000: taken = (a == b);
					3'b001: taken = (a != b);
					3'b100: taken = $signed(a) < $signed(b);
					3'b101: taken = $signed(a) >= $signed(b);
					default: taken = 1'b0;
				endcase
				if (taken)
					npc = pc + bimm;
			end
			OP_IMM, OP_REG: begin
				op_b = (ins[6:0] == OP_REG) ? b : iimm;
				wr = 1'b1;
				case (ins[14:12])
					3'b000: v = (ins[6:0] == OP_REG && ins[31:25] == 7'b0100000) ?
						a - op_b : a + op_b;
					3'b010: v = {31'h0, $signed(a) < $signed(op_b)};
					3'b100: v = a ^ op_b;
					3'b110: v = a | op_b;
					3'b111: v = a & op_b;
					default: v = 32'h0;
				endcase
			end
			OP_LOAD: begin
				ea = a + iimm;
				if (ins[14:12] == 3'b010) begin
					if (ea[31:10] == RESET_PC[31:10]) begin
						v = m[ea[9:2]];
						wr = 1'b1;
					end else
						npc = RESET_PC; // bus error restarts
				end
			end
			OP_STORE: begin
				ea = a + simm;
				if (ins[14:12] == 3'b010) begin
					exp_addr.push_back(ea);
					exp_data.push_back(b);
					if (ea == STOP_ADDR)
						return n;
					if (ea[31:10] == RESET_PC[31:10])
						m[ea[9:2]] = b;
					else
						npc = RESET_PC;
				end
			end
			default: ;
		endcase
		if (wr && ins[10:7] != 4'd0) // rv32e keeps only four bits of rd
			r[ins[10:7]] = v;
		pc = npc;
	end
	return n;
endfunction

`endif

// File: tb/tb_core.sv
`default_nettype none

module tb_core;
	import rv_pkg::*;

	logic        clock, arst_n;
	logic        mem_req_valid, mem_req_ready, mem_write, mem_resp_valid, mem_resp_err;
	logic [31:0] mem_addr, mem_wdata, mem_rdata;
	logic [3:0]  mem_wstrb;
	logic        retire;

	logic [31:0] img [256];
	logic [31:0] mem [256];
	int          pcnt, slot, errors, retire_cnt, lat;
	logic        running, busy, resp_err, first_req, expect_restart, stop_seen, run_done;
	logic        ready_now;
	logic [31:0] resp_data, ea, ed;

	`include "tb_ref_model.svh"

	rv_core dut (
		.clock(clock), .arst_n(arst_n),
		.mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
		.mem_addr(mem_addr), .mem_write(mem_write), .mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb), .mem_resp_valid(mem_resp_valid),
		.mem_rdata(mem_rdata), .mem_resp_err(mem_resp_err), .retire(retire)
	);

	always #10 clock = ~clock;

	task automatic report_mismatch(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		errors++;
	endtask

	// memory model that also compares every store
	always @(negedge clock) begin
		if (!running) begin
			mem_req_ready <= 1'b0;
			mem_resp_valid <= 1'b0;
			mem_resp_err <= 1'b0;
			busy = 1'b0;
		end else begin
			if (retire) begin
				retire_cnt++;
				if (stop_seen)
					run_done = 1'b1;
			end
			mem_resp_valid <= 1'b0;
			mem_resp_err <= 1'b0;
			if (busy) begin
				lat--;
				if (lat == 0) begin
					busy = 1'b0;
					mem_resp_valid <= 1'b1;
					mem_resp_err <= resp_err;
					mem_rdata <= resp_data;
					if (resp_err)
						expect_restart = 1'b1;
				end
			end
			ready_now = (rand_bits(2) != 32'd0); // low about a quarter of the time
			mem_req_ready <= ready_now;
			if (ready_now && mem_req_valid && !busy) begin
				if (first_req) begin
					first_req = 1'b0;
					if (mem_addr != RESET_PC || mem_write || retire_cnt != 0)
						report_mismatch($sformatf("first request addr %h write %b after %0d retires",
							mem_addr, mem_write, retire_cnt));
				end
				if (expect_restart) begin
					expect_restart = 1'b0;
					if (mem_addr != RESET_PC)
						report_mismatch($sformatf("request after error at %h, not reset pc",
							mem_addr));
				end
				resp_err = (mem_addr[31:10] != RESET_PC[31:10]);
				resp_data = resp_err ? 32'h0 : mem[mem_addr[9:2]];
				if (mem_write) begin
					if (exp_addr.size() == 0) begin
						report_mismatch($sformatf("unexpected store %h to %h", mem_wdata, mem_addr));
					end else begin
						ea = exp_addr.pop_front();
						ed = exp_data.pop_front();
						if (mem_addr != ea || mem_wdata != ed || mem_wstrb != 4'hf)
							report_mismatch($sformatf("store %h to %h, expected %h to %h",
								mem_wdata, mem_addr, ed, ea));
					end
					if (!resp_err)
						mem[mem_addr[9:2]] = mem_wdata;
					if (mem_addr == STOP_ADDR)
						stop_seen = 1'b1;
				end
				busy = 1'b1;
				lat = 1 + (rand_bits(2) % 3);
			end
		end
	end

	function automatic logic [31:0] enc_i(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
		logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP_REG};
	endfunction

	function automatic logic [31:0] enc_s(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OP_STORE};
	endfunction

	function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
		logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
	endfunction

	function automatic logic [2:0] pick_alu_f3(logic [31:0] n);
		case (n)
			0: return F3_ADD;
			1: return F3_SLT;
			2: return F3_XOR;
			3: return F3_OR;
			default: return F3_AND;
		endcase
	endfunction

	function automatic logic [4:0] rand_reg();
		return 5'(1 + rand_bits(4) % 14); // x15 holds the data base
	endfunction

	task automatic put(input logic [31:0] w);
		img[pcnt] = w;
		pcnt++;
	endtask

	task automatic put_store(input logic [4:0] rs);
		put(enc_s(rs, 5'd15, 12'(12'h200 + slot * 4)));
		slot++;
	endtask

	task automatic start_image(input bit init_regs);
		for (int i = 0; i < 256; i++)
			img[i] = (RESET_PC + 32'(i * 4)) ^ 32'h5a5a_c3c3;
		img[254] = 32'h0; // restart flag
		pcnt = 0;
		slot = 0;
		put({20'h30000, 5'd15, OP_LUI});
		if (init_regs)
			for (int i = 1; i < 15; i++)
				put(enc_i(OP_IMM, F3_ADD, 5'(i), 5'd0, 12'(rand_bits(12))));
	endtask

	task automatic run_prog(input string name);
		int n_exp, errs0, i;
		put(enc_s(5'd0, 5'd15, 12'h3fc));
		errs0 = errors;
		n_exp = ref_run();
		@(negedge clock);
		arst_n = 1'b0;
		for (i = 0; i < 256; i++)
			mem[i] = img[i];
		@(negedge clock);
		@(negedge clock);
		if (mem_req_valid || retire)
			report_mismatch("request or retire active in reset");
		arst_n = 1'b1;
		@(posedge clock);
		retire_cnt = 0;
		first_req = 1'b1;
		expect_restart = 1'b0;
		stop_seen = 1'b0;
		run_done = 1'b0;
		running = 1'b1;
		for (i = 0; i < 20000 && !run_done; i++)
			@(negedge clock);
		if (!run_done) begin
			$display("timeout in %s: the core never retired the final store", name);
			$display("Test failures found");
			$finish;
		end
		@(posedge clock);
		running = 1'b0;
		if (retire_cnt != n_exp)
			report_mismatch($sformatf("retired %0d, expected %0d", retire_cnt, n_exp));
		if (exp_addr.size() != 0)
			report_mismatch($sformatf("%0d expected stores never seen", exp_addr.size()));
		$display("%-8s %s  retired %0d", name, (errors == errs0) ? "ok" : "FAILED", retire_cnt);
	endtask

	initial begin
		logic [4:0] rd, a, b;
		logic [2:0] f;
		clock = 1'b0;
		arst_n = 1'b0;
		mem_req_ready = 1'b0;
		mem_resp_valid = 1'b0;
		mem_rdata = 32'h0;
		mem_resp_err = 1'b0;
		running = 1'b0;
		busy = 1'b0;
		errors = 0;

		start_image(1'b1);
		for (int k = 0; k < 20; k++) begin
			rd = 5'(rand_bits(4) % 15); // x0 included
			a = rand_reg();
			b = rand_reg();
			f = pick_alu_f3(rand_bits(3) % 5);
			case (rand_bits(2))
				0: put(enc_i(OP_IMM, f, rd, a, 12'(rand_bits(12))));
				1: put(enc_r((rand_bits(1) != 0 && f == F3_ADD) ? F7_SUB : 7'h0, b, a, f, rd));
				2: put({20'(rand_bits(20)), rd, OP_LUI});
				default: put({20'(rand_bits(20)), rd, OP_AUIPC});
			endcase
			put_store(rd);
		end
		run_prog("alu");

		start_image(1'b1);
		for (int k = 0; k < 10; k++) begin
			a = rand_reg();
			b = (rand_bits(1) != 0) ? a : rand_reg();
			case (rand_bits(2))
				0: f = F3_BEQ;
				1: f = F3_BNE;
				2: f = F3_BLT;
				default: f = F3_BGE;
			endcase
			put(enc_b(f, a, b, 13'd8)); // taken skips the first store
			put_store(a);
			put_store(b);
		end
		put(enc_j(5'd5, 21'd8));
		put_store(5'd1);
		put_store(5'd5);
		put({20'h0, 5'd6, OP_AUIPC});
		put(enc_i(OP_JALR, 3'b000, 5'd7, 5'd6, 12'd12));
		put_store(5'd2);
		put_store(5'd7);
		run_prog("branch");

		start_image(1'b1);
		for (int k = 0; k < 8; k++) begin
			a = rand_reg();
			rd = rand_reg();
			put(enc_i(OP_IMM, F3_XOR, a, a, 12'(rand_bits(12))));
			put(enc_s(a, 5'd15, 12'(12'h300 + k * 4)));
			put(enc_i(OP_LOAD, F3_WORD, rd, 5'd15, 12'(12'h300 + k * 4)));
			put_store(rd);
			put(enc_i(OP_LOAD, F3_WORD, rd, 5'd15, 12'(12'h380 + k * 4))); // fill pattern
			put_store(rd);
		end
		run_prog("memory");

		// second pass after the restart skips straight to the store of x3
		start_image(1'b0);
		put(enc_i(OP_LOAD, F3_WORD, 5'd2, 5'd15, 12'h3f8));
		put(enc_b(F3_BNE, 5'd2, 5'd0, 13'd20));
		put(enc_i(OP_IMM, F3_ADD, 5'd2, 5'd0, 12'd1));
		put(enc_s(5'd2, 5'd15, 12'h3f8));
		put(enc_i(OP_IMM, F3_ADD, 5'd3, 5'd0, 12'd77));
		put(enc_i(OP_LOAD, F3_WORD, 5'd3, 5'd0, 12'd0)); // unmapped
		put_store(5'd3);
		run_prog("error");

		$display("tests 4  check failures %0d", errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/rv_core.sv
`default_nettype none

module rv_core (
	input  logic        clock,
	input  logic        arst_n,
	output logic        mem_req_valid,
	input  logic        mem_req_ready,
	output logic [31:0] mem_addr,
	output logic        mem_write,
	output logic [31:0] mem_wdata,
	output logic [3:0]  mem_wstrb,
	input  logic        mem_resp_valid,
	input  logic [31:0] mem_rdata,
	input  logic        mem_resp_err,
	output logic        retire
);
	import rv_pkg::*;

	inst_u       inst;
	logic        inst_valid, fetch_err;
	logic [31:0] pc, exec_next_pc, fetch_next_pc;
	logic        fetch_req_valid, fetch_req_ready, fetch_resp_valid, fetch_resp_err;
	logic [31:0] fetch_addr, fetch_rdata;
	logic        lsu_req_valid, lsu_req_ready, lsu_write, lsu_resp_valid, lsu_resp_err;
	logic [31:0] lsu_addr, lsu_wdata, lsu_rdata;
	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic        funct7_sub, is_load, is_store, reg_wen;
	logic [3:0]  rs1, rs2, rd;
	logic [31:0] imm, src1, src2, result, data_addr, load_data;
	logic        lsu_start, lsu_done, lsu_err, data_err, mem_op, retire_d;

	assign mem_op = is_load || is_store;
	// held during the retire cycle too, so retire masks a second start
	assign lsu_start = inst_valid && mem_op && !fetch_err && !retire;
	assign retire_d = !retire && (lsu_done || (inst_valid && (!mem_op || fetch_err)));

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			retire <= 1'b0;
			data_err <= 1'b0;
		end else begin
			retire <= retire_d;
			data_err <= lsu_err; // lines up with retire
		end
	end

	assign fetch_next_pc = data_err ? RESET_PC : exec_next_pc; // data errors restart too

	rv_fetch u_fetch (
		.clock(clock), .arst_n(arst_n), .retire(retire), .next_pc(fetch_next_pc),
		.fetch_req_ready(fetch_req_ready), .fetch_resp_valid(fetch_resp_valid),
		.fetch_rdata(fetch_rdata), .fetch_resp_err(fetch_resp_err),
		.fetch_req_valid(fetch_req_valid), .fetch_addr(fetch_addr), .pc(pc),
		.inst(inst), .inst_valid(inst_valid), .fetch_err(fetch_err)
	);

	rv_decode u_decode (
		.inst(inst), .opcode(opcode), .funct3(funct3), .funct7_sub(funct7_sub),
		.rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
		.is_load(is_load), .is_store(is_store), .reg_wen(reg_wen)
	);

	rv_regfile u_regfile (
		.clock(clock), .wen(retire && reg_wen && !fetch_err && !data_err),
		.waddr(rd), .wdata(is_load ? load_data : result),
		.raddr1(rs1), .raddr2(rs2), .rdata1(src1), .rdata2(src2)
	);

	rv_exec u_exec (
		.opcode(opcode), .funct3(funct3), .funct7_sub(funct7_sub), .pc(pc),
		.src1(src1), .src2(src2), .imm(imm),
		.result(result), .next_pc(exec_next_pc), .mem_addr(data_addr)
	);

	rv_lsu u_lsu (
		.clock(clock), .arst_n(arst_n), .start(lsu_start), .is_store(is_store),
		.addr(data_addr), .store_data(src2),
		.lsu_req_ready(lsu_req_ready), .lsu_resp_valid(lsu_resp_valid),
		.lsu_rdata(lsu_rdata), .lsu_resp_err(lsu_resp_err),
		.lsu_req_valid(lsu_req_valid), .lsu_addr(lsu_addr), .lsu_write(lsu_write),
		.lsu_wdata(lsu_wdata), .load_data(load_data), .done(lsu_done), .err(lsu_err)
	);

	rv_bus_arb u_arb (
		.clock(clock), .arst_n(arst_n),
		.fetch_req_valid(fetch_req_valid), .fetch_req_ready(fetch_req_ready),
		.fetch_addr(fetch_addr), .fetch_resp_valid(fetch_resp_valid),
		.fetch_rdata(fetch_rdata), .fetch_resp_err(fetch_resp_err),
		.lsu_req_valid(lsu_req_valid), .lsu_req_ready(lsu_req_ready),
		.lsu_addr(lsu_addr), .lsu_write(lsu_write), .lsu_wdata(lsu_wdata),
		.lsu_resp_valid(lsu_resp_valid), .lsu_rdata(lsu_rdata), .lsu_resp_err(lsu_resp_err),
		.mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
		.mem_addr(mem_addr), .mem_write(mem_write), .mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb), .mem_resp_valid(mem_resp_valid),
		.mem_rdata(mem_rdata), .mem_resp_err(mem_resp_err)
	);

endmodule

`default_nettype wire

// File: hw/rv_bus_arb.sv
`default_nettype none

module rv_bus_arb (
	input  logic        clock,
	input  logic        arst_n,
	input  logic        fetch_req_valid,
	output logic        fetch_req_ready,
	input  logic [31:0] fetch_addr,
	output logic        fetch_resp_valid,
	output logic [31:0] fetch_rdata,
	output logic        fetch_resp_err,
	input  logic        lsu_req_valid,
	output logic        lsu_req_ready,
	input  logic [31:0] lsu_addr,
	input  logic        lsu_write,
	input  logic [31:0] lsu_wdata,
	output logic        lsu_resp_valid,
	output logic [31:0] lsu_rdata,
	output logic        lsu_resp_err,
	output logic        mem_req_valid,
	input  logic        mem_req_ready,
	output logic [31:0] mem_addr,
	output logic        mem_write,
	output logic [31:0] mem_wdata,
	output logic [3:0]  mem_wstrb,
	input  logic        mem_resp_valid,
	input  logic [31:0] mem_rdata,
	input  logic        mem_resp_err
);

	logic owner_lsu; // who gets the outstanding response

	assign mem_req_valid = lsu_req_valid || fetch_req_valid;
	assign mem_addr  = lsu_req_valid ? lsu_addr : fetch_addr;
	assign mem_write = lsu_req_valid && lsu_write;
	assign mem_wdata = lsu_wdata;
	assign mem_wstrb = {4{mem_write}}; // word stores only

	assign lsu_req_ready   = mem_req_ready && lsu_req_valid;
	assign fetch_req_ready = mem_req_ready && !lsu_req_valid;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			owner_lsu <= 1'b0;
		else if (mem_req_valid && mem_req_ready)
			owner_lsu <= lsu_req_valid;
		else if (mem_resp_valid)
			owner_lsu <= 1'b0;
	end

	assign fetch_resp_valid = mem_resp_valid && !owner_lsu;
	assign lsu_resp_valid   = mem_resp_valid && owner_lsu;
	assign fetch_rdata    = mem_rdata;
	assign lsu_rdata      = mem_rdata;
	assign fetch_resp_err = mem_resp_err;
	assign lsu_resp_err   = mem_resp_err;

endmodule

`default_nettype wire

// File: hw/rv_lsu.sv
`default_nettype none

module rv_lsu (
	input  logic        clock,
	input  logic        arst_n,
	input  logic        start,
	input  logic        is_store,
	input  logic [31:0] addr,
	input  logic [31:0] store_data,
	input  logic        lsu_req_ready,
	input  logic        lsu_resp_valid,
	input  logic [31:0] lsu_rdata,
	input  logic        lsu_resp_err,
	output logic        lsu_req_valid,
	output logic [31:0] lsu_addr,
	output logic        lsu_write,
	output logic [31:0] lsu_wdata,
	output logic [31:0] load_data,
	output logic        done,
	output logic        err
);
	import rv_pkg::*;

	logic [1:0] state;

	assign lsu_req_valid = (state == LS_REQ);
	assign done = (state == LS_WAIT) && lsu_resp_valid;
	assign err  = done && lsu_resp_err;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= LS_IDLE;
		end else begin
			case (state)
				LS_IDLE: begin
					if (start)
						state <= LS_REQ;
				end
				LS_REQ: begin
					if (lsu_req_ready)
						state <= LS_WAIT;
				end
				LS_WAIT: begin
					if (lsu_resp_valid)
						state <= LS_IDLE;
				end
				default: state <= LS_IDLE;
			endcase
		end
	end

	// request fields stay put while the bus stalls
	always_ff @(posedge clock) begin
		if (state == LS_IDLE && start) begin
			lsu_addr <= addr;
			lsu_write <= is_store;
			lsu_wdata <= store_data;
		end
		if (done)
			load_data <= lsu_rdata;
	end

endmodule

`default_nettype wire

// File: hw/rv_exec.sv
`default_nettype none

module rv_exec (
	input  logic [6:0]  opcode,
	input  logic [2:0]  funct3,
	input  logic        funct7_sub,
	input  logic [31:0] pc,
	input  logic [31:0] src1,
	input  logic [31:0] src2,
	input  logic [31:0] imm,
	output logic [31:0] result,
	output logic [31:0] next_pc,
	output logic [31:0] mem_addr
);
	import rv_pkg::*;

	logic [31:0] op_b;
	logic [31:0] alu;
	logic [31:0] snpc;
	logic        taken;

	assign op_b = (opcode == OP_REG) ? src2 : imm;
	assign snpc = pc + 32'd4;
	assign mem_addr = src1 + imm;

	always_comb begin
		case (funct3)
			F3_ADD: alu = (opcode == OP_REG && funct7_sub) ? src1 - op_b : src1 + op_b;
			F3_SLT: alu = {31'h0, $signed(src1) < $signed(op_b)};
			F3_XOR: alu = src1 ^ op_b;
			F3_OR:  alu = src1 | op_b;
			F3_AND: alu = src1 & op_b;
			default: alu = 32'h0;
		endcase
	end

	always_comb begin
		case (funct3)
			F3_BEQ: taken = (src1 == src2);
			F3_BNE: taken = (src1 != src2);
			F3_BLT: taken = $signed(src1) < $signed(src2);
			F3_BGE: taken = $signed(src1) >= $signed(src2);
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (opcode)
			OP_LUI:          result = imm;
			OP_AUIPC:        result = pc + imm;
			OP_JAL, OP_JALR: result = snpc; // link
			OP_IMM, OP_REG:  result = alu;
			default:         result = 32'h0;
		endcase
	end

	always_comb begin
		case (opcode)
			OP_JAL:    next_pc = pc + imm;
			OP_JALR:   next_pc = mem_addr & ~32'h1;
			OP_BRANCH: next_pc = taken ? pc + imm : snpc;
			default:   next_pc = snpc;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/rv_regfile.sv
`default_nettype none

module rv_regfile (
	input  logic        clock,
	input  logic        wen,
	input  logic [3:0]  waddr,
	input  logic [31:0] wdata,
	input  logic [3:0]  raddr1,
	input  logic [3:0]  raddr2,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2
);
	import rv_pkg::*;

	logic [XLEN-1:0] regs [REG_COUNT];

	always_ff @(posedge clock) begin
		if (wen && waddr != 4'd0)
			regs[waddr] <= wdata;
	end

	// x0 is hardwired
	assign rdata1 = (raddr1 == 4'd0) ? 32'h0 : regs[raddr1];
	assign rdata2 = (raddr2 == 4'd0) ? 32'h0 : regs[raddr2];

endmodule

`default_nettype wire

// File: hw/rv_decode.sv
`default_nettype none

module rv_decode (
	input  rv_pkg::inst_u inst,
	output logic [6:0]    opcode,
	output logic [2:0]    funct3,
	output logic          funct7_sub,
	output logic [3:0]    rs1,
	output logic [3:0]    rs2,
	output logic [3:0]    rd,
	output logic [31:0]   imm,
	output logic          is_load,
	output logic          is_store,
	output logic          reg_wen
);
	import rv_pkg::*;

	assign opcode = inst.r_fmt.opcode;
	assign funct3 = inst.r_fmt.funct3;
	assign funct7_sub = (inst.r_fmt.funct7 == F7_SUB);

	// rv32e only has 16 registers, top bit dropped
	assign rs1 = inst.r_fmt.rs1[3:0];
	assign rs2 = inst.r_fmt.rs2[3:0];
	assign rd  = inst.r_fmt.rd[3:0];

	assign is_load  = (opcode == OP_LOAD) && (funct3 == F3_WORD);
	assign is_store = (opcode == OP_STORE) && (funct3 == F3_WORD);

	always_comb begin
		case (opcode)
			OP_IMM, OP_LOAD, OP_JALR:
				imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
			OP_STORE:
				imm = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
			OP_BRANCH:
				imm = {{20{inst.b_fmt.imm12}}, inst.b_fmt.imm11, inst.b_fmt.imm10_5,
					inst.b_fmt.imm4_1, 1'b0};
			OP_LUI, OP_AUIPC:
				imm = {inst.u_fmt.imm, 12'h000};
			OP_JAL:
				imm = {{12{inst.j_fmt.imm20}}, inst.j_fmt.imm19_12, inst.j_fmt.imm11,
					inst.j_fmt.imm10_1, 1'b0};
			default: imm = 32'h0;
		endcase
	end

	always_comb begin
		case (opcode)
			OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_IMM, OP_REG: reg_wen = 1'b1;
			OP_LOAD: reg_wen = is_load; // narrow loads are no-ops
			default: reg_wen = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/rv_fetch.sv
`default_nettype none

module rv_fetch (
	input  logic          clock,
	input  logic          arst_n,
	input  logic          retire,
	input  logic [31:0]   next_pc,
	input  logic          fetch_req_ready,
	input  logic          fetch_resp_valid,
	input  logic [31:0]   fetch_rdata,
	input  logic          fetch_resp_err,
	output logic          fetch_req_valid,
	output logic [31:0]   fetch_addr,
	output logic [31:0]   pc,
	output rv_pkg::inst_u inst,
	output logic          inst_valid,
	output logic          fetch_err
);
	import rv_pkg::*;

	logic [1:0] state;
	logic       resp_take;

	assign fetch_req_valid = (state == FS_REQ);
	assign fetch_addr = pc;
	assign resp_take = (state == FS_WAIT) && fetch_resp_valid;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= FS_HOLD; // nothing latched yet, so hold drops straight to request
			pc <= RESET_PC;
			inst_valid <= 1'b0;
			fetch_err <= 1'b0;
		end else if (retire) begin
			pc <= fetch_err ? RESET_PC : next_pc; // bad fetch restarts
			inst_valid <= 1'b0;
			state <= FS_REQ;
		end else begin
			case (state)
				FS_REQ: begin
					if (fetch_req_ready)
						state <= FS_WAIT;
				end
				FS_WAIT: begin
					if (fetch_resp_valid) begin
						inst_valid <= 1'b1;
						fetch_err <= fetch_resp_err;
						state <= FS_HOLD;
					end
				end
				FS_HOLD: begin
					if (!inst_valid)
						state <= FS_REQ;
				end
				default: state <= FS_HOLD;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (resp_take)
			inst <= fetch_rdata;
	end

endmodule

`default_nettype wire

// File: hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

	localparam int XLEN = 32;
	localparam int REG_COUNT = 16; // RV32E

	localparam logic [31:0] RESET_PC = 32'h3000_0000;

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;

	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_WORD = 3'b010;

	localparam logic [6:0] F7_SUB = 7'b0100000;

	// fetch fsm
	localparam logic [1:0] FS_REQ  = 2'd0;
	localparam logic [1:0] FS_WAIT = 2'd1;
	localparam logic [1:0] FS_HOLD = 2'd2;

	// lsu fsm
	localparam logic [1:0] LS_IDLE = 2'd0;
	localparam logic [1:0] LS_REQ  = 2'd1;
	localparam logic [1:0] LS_WAIT = 2'd2;

	// one instruction word, seen through each encoding format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_fmt;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s_fmt;
		struct packed {
			logic       imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic       imm11;
			logic [6:0] opcode;
		} b_fmt;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u_fmt;
		struct packed {
			logic       imm20;
			logic [9:0] imm10_1;
			logic       imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j_fmt;
	} inst_u;

endpackage

`default_nettype wire
